//--- Makefile
# Verilator build and run of the SHA-256 testbench

VERILATOR ?= verilator
TOP       ?= tb_sha256
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
sha256_pkg.sv
sha256_w_mem.sv
sha256_core.sv
sha256_regs.sv
sha256.sv
tb_sha256.sv

//--- sha256.sv
// SHA-256 accelerator top
`default_nettype none

module sha256 (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              awvalid,
  output logic              awready,
  input  sha256_pkg::addr_t awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  sha256_pkg::word_t wdata,
  input  logic [3:0]        wstrb,
  output logic              bvalid,
  input  logic              bready,
  output sha256_pkg::resp_t bresp,
  input  logic              arvalid,
  output logic              arready,
  input  sha256_pkg::addr_t araddr,
  output logic              rvalid,
  input  logic              rready,
  output sha256_pkg::word_t rdata,
  output sha256_pkg::resp_t rresp,
  output logic              error_intr,
  output logic              notif_intr
);

  // Register block to core and back
  sha256_pkg::core_cmd_t cmd;
  sha256_pkg::core_rsp_t rsp;

  sha256_regs u_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rsp        (rsp),
    .cmd        (cmd),
    .error_intr (error_intr),
    .notif_intr (notif_intr)
  );

  sha256_core u_core (
    .clk     (clk),
    .reset_n (reset_n),
    .cmd     (cmd),
    .rsp     (rsp)
  );

endmodule

`default_nettype wire

//--- sha256_core.sv
// SHA-256 compression core
`default_nettype none

module sha256_core (
  input  logic                  clk,
  input  logic                  reset_n,
  input  sha256_pkg::core_cmd_t cmd,
  output sha256_pkg::core_rsp_t rsp
);

  sha256_pkg::core_state_t state;
  sha256_pkg::round_t      round;
  sha256_pkg::digest_t     h_q;
  // Working variables a..h, a in the top word
  sha256_pkg::digest_t     wv_q;
  sha256_pkg::digest_t     start_h;
  sha256_pkg::word_t       w;
  logic                    start;
  logic                    digest_valid_q;

  // --------------------
  // Round functions
  // --------------------
  function automatic sha256_pkg::word_t big_sigma0(sha256_pkg::word_t x);
    return sha256_pkg::rotr(x, 2) ^ sha256_pkg::rotr(x, 13) ^ sha256_pkg::rotr(x, 22);
  endfunction

  function automatic sha256_pkg::word_t big_sigma1(sha256_pkg::word_t x);
    return sha256_pkg::rotr(x, 6) ^ sha256_pkg::rotr(x, 11) ^ sha256_pkg::rotr(x, 25);
  endfunction

  // One compression step, kw is K[t] + W[t]
  function automatic sha256_pkg::digest_t round_step(sha256_pkg::digest_t v,
                                                     sha256_pkg::word_t kw);
    sha256_pkg::word_t a, b, c, d, e, f, g, h;
    sha256_pkg::word_t t1, t2;
    {a, b, c, d, e, f, g, h} = v;
    t1 = h + big_sigma1(e) + ((e & f) ^ (~e & g)) + kw;
    t2 = big_sigma0(a) + ((a & b) ^ (a & c) ^ (b & c));
    return {t1 + t2, a, b, c, d + t1, e, f, g};
  endfunction

  // Word-wise add of two hash states
  function automatic sha256_pkg::digest_t add_words(sha256_pkg::digest_t x,
                                                    sha256_pkg::digest_t y);
    sha256_pkg::digest_t sum;
    for (int i = 0; i < 8; i++) begin
      sum[i * 32 +: 32] = x[i * 32 +: 32] + y[i * 32 +: 32];
    end
    return sum;
  endfunction

  // --------------------
  // Control
  // --------------------
  // Commands count only while idle
  assign start = (cmd.init | cmd.next) && (state == sha256_pkg::idle);

  // Init restarts the chain; next continues from the last digest
  always_comb begin
    start_h = h_q;
    if (cmd.init) begin
      start_h = cmd.mode ? sha256_pkg::h0_sha224 : sha256_pkg::h0_sha256;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state          <= sha256_pkg::idle;
      round          <= '0;
      digest_valid_q <= 1'b0;
      h_q            <= '0;
    end else begin
      case (state)
        sha256_pkg::idle: begin
          if (start) begin
            state          <= sha256_pkg::rounds;
            round          <= '0;
            digest_valid_q <= 1'b0;
            h_q            <= start_h;
          end
        end
        sha256_pkg::rounds: begin
          round <= round + 6'd1;
          if (round == 6'd63) begin
            state <= sha256_pkg::finish;
          end
        end
        sha256_pkg::finish: begin
          // Fold working variables into the chain
          h_q            <= add_words(h_q, wv_q);
          digest_valid_q <= 1'b1;
          state          <= sha256_pkg::idle;
        end
        default: state <= sha256_pkg::idle;
      endcase
    end
  end

  // Datapath, one round per cycle
  always_ff @(posedge clk) begin
    if (start) begin
      wv_q <= start_h;
    end else if (state == sha256_pkg::rounds) begin
      wv_q <= round_step(wv_q, sha256_pkg::k_table[round] + w);
    end
  end

  sha256_w_mem u_w_mem (
    .clk     (clk),
    .reset_n (reset_n),
    .block   (cmd.block),
    .load    (start),
    .advance (state == sha256_pkg::rounds),
    .w       (w)
  );

  assign rsp.ready        = (state == sha256_pkg::idle);
  assign rsp.digest_valid = digest_valid_q;
  assign rsp.digest       = h_q;

endmodule

`default_nettype wire

//--- sha256_input.txt
# Record: v, mode (0 SHA-256, 1 SHA-224), block count, 16 hex words per block, 8 digest words
# Digest word 0 is h0; for SHA-224 the eighth word is a filler and is not compared
v 0 1
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018
ba7816bf 8f01cfea 414140de 5dae2223 b00361a3 96177a9c b410ff61 f20015ad
v 1 1
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018
23097d22 3405d822 8642a477 bda255b3 2aadbce4 bda0b3f7 e36c9da7 00000000
v 0 2
61626364 62636465 63646566 64656667 65666768 66676869 6768696a 68696a6b
696a6b6c 6a6b6c6d 6b6c6d6e 6c6d6e6f 6d6e6f70 6e6f7071 80000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 000001c0
248d6a61 d20638b8 e5c02693 0c3e6039 a33ce459 64ff2167 f6ecedd4 19db06c1

//--- sha256_pkg.sv
// SHA-256 shared definitions
`default_nettype none

package sha256_pkg;

  // --------------------
  // Widths
  // --------------------
  typedef logic [31:0]  word_t;
  typedef logic [7:0]   addr_t;
  typedef logic [511:0] block_t;
  // Word 0 (h0 or a) sits in the top 32 bits
  typedef logic [255:0] digest_t;
  typedef logic [5:0]   round_t;
  typedef logic [1:0]   resp_t;

  // AXI response codes
  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // Register byte offsets
  localparam addr_t ctrl_off     = 8'h00;
  localparam addr_t status_off   = 8'h04;
  localparam addr_t intr_sts_off = 8'h08;
  localparam addr_t intr_en_off  = 8'h0C;
  localparam addr_t block_off    = 8'h40;
  localparam addr_t digest_off   = 8'h80;

  // --------------------
  // Hash constants
  // --------------------
  localparam word_t k_table [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial chaining values, h0 first
  localparam digest_t h0_sha256 = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };
  localparam digest_t h0_sha224 = {
    32'hc1059ed8, 32'h367cd507, 32'h3070dd17, 32'hf70e5939,
    32'hffc00b31, 32'h68581511, 32'h64f98fa7, 32'hbefa4fa4
  };

  // Rotate right, used by both schedule and round logic
  function automatic word_t rotr(word_t x, int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // --------------------
  // Core interface
  // --------------------
  typedef struct packed {
    logic   init;
    logic   next;
    logic   mode;
    block_t block;
  } core_cmd_t;

  typedef struct packed {
    logic    ready;
    logic    digest_valid;
    digest_t digest;
  } core_rsp_t;

  typedef enum logic [1:0] {
    idle,
    rounds,
    finish
  } core_state_t;

endpackage

`default_nettype wire

//--- sha256_regs.sv
// SHA-256 AXI4-Lite registers
`default_nettype none

module sha256_regs (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  awvalid,
  output logic                  awready,
  input  sha256_pkg::addr_t     awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  sha256_pkg::word_t     wdata,
  // Full-word writes only, strobes ignored
  input  logic [3:0]            wstrb,
  output logic                  bvalid,
  input  logic                  bready,
  output sha256_pkg::resp_t     bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  sha256_pkg::addr_t     araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output sha256_pkg::word_t     rdata,
  output sha256_pkg::resp_t     rresp,
  input  sha256_pkg::core_rsp_t rsp,
  output sha256_pkg::core_cmd_t cmd,
  output logic                  error_intr,
  output logic                  notif_intr
);

  sha256_pkg::word_t block_q [16];
  sha256_pkg::word_t rd_data;
  logic mode_q, init_q, next_q;
  logic notif_sts, error_sts, notif_en, error_en;
  logic valid_q;
  logic wr_fire, rd_fire, rd_err, wr_err;
  logic wr_ctrl, wr_ists, wr_ien, wr_blk, cmd_busy;
  logic notif_set, error_set;

  // Aligned word inside a window of registers
  function automatic logic in_range(sha256_pkg::addr_t a, sha256_pkg::addr_t base,
                                    int unsigned words);
    return (a[1:0] == 2'b00) && (a >= base) && (int'(a) < int'(base) + 4 * words);
  endfunction

  // --------------------
  // Handshakes
  // --------------------
  // aw and w only complete together, never one alone
  assign awready = ~bvalid & (wvalid | ~awvalid);
  assign wready  = ~bvalid & (awvalid | ~wvalid);
  assign arready = ~rvalid;
  assign wr_fire = awvalid & wvalid & ~bvalid;
  assign rd_fire = arvalid & ~rvalid;

  // Write decode; status and digest are read-only
  assign wr_ctrl = (awaddr == sha256_pkg::ctrl_off);
  assign wr_ists = (awaddr == sha256_pkg::intr_sts_off);
  assign wr_ien  = (awaddr == sha256_pkg::intr_en_off);
  assign wr_blk  = in_range(awaddr, sha256_pkg::block_off, 16);
  assign wr_err  = ~(wr_ctrl | wr_ists | wr_ien | wr_blk);
  // Command while hashing, dropped but answered OKAY
  assign cmd_busy = wr_ctrl & (wdata[0] | wdata[1]) & ~rsp.ready;

  // Read mux
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    if (araddr == sha256_pkg::ctrl_off) begin
      rd_data = {29'b0, mode_q, 2'b00};
    end else if (araddr == sha256_pkg::status_off) begin
      rd_data = {30'b0, rsp.digest_valid, rsp.ready};
    end else if (araddr == sha256_pkg::intr_sts_off) begin
      rd_data = {30'b0, error_sts, notif_sts};
    end else if (araddr == sha256_pkg::intr_en_off) begin
      rd_data = {30'b0, error_en, notif_en};
    end else if (in_range(araddr, sha256_pkg::block_off, 16)) begin
      rd_data = block_q[araddr[5:2]];
    end else if (in_range(araddr, sha256_pkg::digest_off, 8)) begin
      rd_data = rsp.digest[(7 - int'(araddr[4:2])) * 32 +: 32];
    end else begin
      rd_err = 1'b1;
    end
  end

  // Completion on the rising edge of digest_valid
  assign notif_set = rsp.digest_valid & ~valid_q;
  assign error_set = (wr_fire & (wr_err | cmd_busy)) | (rd_fire & rd_err);

  // --------------------
  // Control registers
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      bvalid     <= 1'b0;
      bresp      <= sha256_pkg::resp_okay;
      rvalid     <= 1'b0;
      rdata      <= '0;
      rresp      <= sha256_pkg::resp_okay;
      mode_q     <= 1'b0;
      init_q     <= 1'b0;
      next_q     <= 1'b0;
      notif_en   <= 1'b0;
      error_en   <= 1'b0;
      notif_sts  <= 1'b0;
      error_sts  <= 1'b0;
      valid_q    <= 1'b0;
      notif_intr <= 1'b0;
      error_intr <= 1'b0;
    end else begin
      // Command bits are single-cycle pulses
      init_q  <= 1'b0;
      next_q  <= 1'b0;
      valid_q <= rsp.digest_valid;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= wr_err ? sha256_pkg::resp_slverr : sha256_pkg::resp_okay;
        if (wr_ctrl) begin
          mode_q <= wdata[2];
          init_q <= wdata[0] & rsp.ready;
          next_q <= wdata[1] & rsp.ready;
        end
        if (wr_ien) begin
          notif_en <= wdata[0];
          error_en <= wdata[1];
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
        rdata  <= rd_data;
        rresp  <= rd_err ? sha256_pkg::resp_slverr : sha256_pkg::resp_okay;
      end
      // Sticky status, write 1 to clear, hardware set wins
      notif_sts  <= notif_set | (notif_sts & ~(wr_fire & wr_ists & wdata[0]));
      error_sts  <= error_set | (error_sts & ~(wr_fire & wr_ists & wdata[1]));
      notif_intr <= notif_sts & notif_en;
      error_intr <= error_sts & error_en;
    end
  end

  // Message block words
  always_ff @(posedge clk) begin
    if (wr_fire && wr_blk) begin
      block_q[awaddr[5:2]] <= wdata;
    end
  end

  // Command to the core, word 0 in the top bits
  always_comb begin
    cmd.init = init_q;
    cmd.next = next_q;
    cmd.mode = mode_q;
    for (int i = 0; i < 16; i++) begin
      cmd.block[(15 - i) * 32 +: 32] = block_q[i];
    end
  end

endmodule

`default_nettype wire

//--- sha256_w_mem.sv
// SHA-256 message schedule
`default_nettype none

module sha256_w_mem (
  input  logic               clk,
  input  logic               reset_n,
  input  sha256_pkg::block_t block,
  input  logic               load,
  input  logic               advance,
  output sha256_pkg::word_t  w
);

  // Sliding window, entry 0 is the word of the current round
  sha256_pkg::word_t win [16];
  sha256_pkg::word_t w_new;

  function automatic sha256_pkg::word_t small_sigma0(sha256_pkg::word_t x);
    return sha256_pkg::rotr(x, 7) ^ sha256_pkg::rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic sha256_pkg::word_t small_sigma1(sha256_pkg::word_t x);
    return sha256_pkg::rotr(x, 17) ^ sha256_pkg::rotr(x, 19) ^ (x >> 10);
  endfunction

  // W[t+16] from W[t], W[t+1], W[t+9], W[t+14]
  always_comb begin
    w_new = small_sigma1(win[14]) + win[9] + small_sigma0(win[1]) + win[0];
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 16; i++) begin
        win[i] <= '0;
      end
    end else if (load) begin
      // First message word lives in the top bits of the block
      for (int i = 0; i < 16; i++) begin
        win[i] <= block[(15 - i) * 32 +: 32];
      end
    end else if (advance) begin
      for (int i = 0; i < 15; i++) begin
        win[i] <= win[i + 1];
      end
      win[15] <= w_new;
    end
  end

  assign w = win[0];

endmodule

`default_nettype wire

//--- tb_sha256.sv
// SHA-256 accelerator testbench
`default_nettype none

module tb_sha256;

  timeunit 1ns;
  timeprecision 100ps;

  // Handshake and polling limits, in cycles or reads
  localparam int hs_limit   = 32;
  localparam int poll_limit = 100;
  localparam int max_cycles = 40000;

  // Selectors for probe()
  localparam int sig_aw_w  = 0;
  localparam int sig_b     = 1;
  localparam int sig_ar    = 2;
  localparam int sig_r     = 3;
  localparam int sig_notif = 4;
  localparam int sig_error = 5;

  logic clk;
  logic reset_n;
  logic awvalid;
  logic awready;
  sha256_pkg::addr_t awaddr;
  logic wvalid;
  logic wready;
  sha256_pkg::word_t wdata;
  logic [3:0] wstrb;
  logic bvalid;
  logic bready;
  sha256_pkg::resp_t bresp;
  logic arvalid;
  logic arready;
  sha256_pkg::addr_t araddr;
  logic rvalid;
  logic rready;
  sha256_pkg::word_t rdata;
  sha256_pkg::resp_t rresp;
  logic error_intr;
  logic notif_intr;

  // Run bookkeeping
  int checks;
  int errors;
  int timeouts;
  bit timed_out;
  bit run_done;
  integer seed;

  // Current vector and the first vector kept for the busy test
  sha256_pkg::word_t blk [2][16];
  sha256_pkg::word_t exp_dig [8];
  sha256_pkg::word_t saved_blk [16];
  sha256_pkg::word_t saved_dig [8];
  logic saved_mode;
  int order [16];

  sha256 DUT (
    .clk        (clk),
    .reset_n    (reset_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .error_intr (error_intr),
    .notif_intr (notif_intr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check_word(input string name, input sha256_pkg::word_t expected,
                            input sha256_pkg::word_t actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    timed_out = 1'b1;
    $display("Timeout while waiting for %s", what);
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      sig_aw_w:  return awready & wready;
      sig_b:     return bvalid;
      sig_ar:    return arready;
      sig_r:     return rvalid;
      sig_notif: return notif_intr;
      default:   return error_intr;
    endcase
  endfunction

  // Sampled at the falling edge, away from the DUT's updates
  task automatic wait_for(input int sel, input logic level, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (probe(sel) !== level && n < hs_limit) begin
      @(negedge clk);
      n++;
    end
    if (probe(sel) !== level) begin
      note_timeout(what);
    end
  endtask

  task automatic idle_gap();
    int n;
    n = $unsigned($random(seed)) % 4;
    repeat (n) @(posedge clk);
  endtask

  // Random write order of the sixteen block words
  task automatic shuffle_order();
    int j;
    int tmp;
    for (int i = 0; i < 16; i++) begin
      order[i] = i;
    end
    for (int i = 15; i > 0; i--) begin
      j = $unsigned($random(seed)) % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
  endtask

  // --------------------
  // AXI4-Lite host
  // --------------------
  task automatic write_reg(input sha256_pkg::addr_t addr, input sha256_pkg::word_t data,
                           output sha256_pkg::resp_t resp);
    idle_gap();
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wait_for(sig_aw_w, 1'b1, "awready and wready");
    // Transfer edge
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    wait_for(sig_b, 1'b1, "bvalid");
    resp = bresp;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_reg(input sha256_pkg::addr_t addr, output sha256_pkg::word_t data,
                          output sha256_pkg::resp_t resp);
    idle_gap();
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    wait_for(sig_ar, 1'b1, "arready");
    @(posedge clk);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    wait_for(sig_r, 1'b1, "rvalid");
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // --------------------
  // Hash sequences
  // --------------------
  task automatic poll_done();
    sha256_pkg::word_t rd;
    sha256_pkg::resp_t rc;
    int polls;
    polls = 0;
    rd = '0;
    while (!rd[1] && polls < poll_limit) begin
      read_reg(sha256_pkg::status_off, rd, rc);
      polls++;
    end
    if (!rd[1]) begin
      note_timeout("status valid after a start");
    end else begin
      // Ready and valid rise together
      check_word("status", 32'h3, rd);
    end
  endtask

  // Load one block, start it, wait for it and clear the completion flag
  task automatic hash_block(input int b, input logic mode, input logic first,
                            input logic inject_next);
    sha256_pkg::word_t rd;
    sha256_pkg::resp_t rc;
    shuffle_order();
    for (int i = 0; i < 16; i++) begin
      write_reg(sha256_pkg::addr_t'(sha256_pkg::block_off + 4 * order[i]),
                blk[b][order[i]], rc);
      check_word("bresp", 32'h0, {30'b0, rc});
    end
    write_reg(sha256_pkg::ctrl_off, {29'b0, mode, ~first, first}, rc);
    check_word("bresp", 32'h0, {30'b0, rc});
    if (inject_next) begin
      // Core busy, the NEXT is dropped but still answered OKAY
      read_reg(sha256_pkg::status_off, rd, rc);
      check_word("status.ready", 32'h0, {31'b0, rd[0]});
      write_reg(sha256_pkg::ctrl_off, {29'b0, mode, 2'b10}, rc);
      check_word("bresp", 32'h0, {30'b0, rc});
    end
    poll_done();
    wait_for(sig_notif, 1'b1, "notif_intr to rise");
    write_reg(sha256_pkg::intr_sts_off, 32'h1, rc);
    read_reg(sha256_pkg::intr_sts_off, rd, rc);
    check_word("intr_sts.notif", 32'h0, {31'b0, rd[0]});
    wait_for(sig_notif, 1'b0, "notif_intr to fall");
  endtask

  // SHA-224 reads back only words 0 to 6
  task automatic check_digest(input logic mode);
    sha256_pkg::word_t rd;
    sha256_pkg::resp_t rc;
    int last;
    last = mode ? 6 : 7;
    for (int i = 0; i <= last; i++) begin
      read_reg(sha256_pkg::addr_t'(sha256_pkg::digest_off + 4 * i), rd, rc);
      check_word($sformatf("digest[%0d]", i), exp_dig[i], rd);
      check_word("rresp", 32'h0, {30'b0, rc});
    end
  endtask

  // Expect the error flag and its interrupt and clear them again
  task automatic verify_error_flag();
    sha256_pkg::word_t rd;
    sha256_pkg::resp_t rc;
    read_reg(sha256_pkg::intr_sts_off, rd, rc);
    check_word("intr_sts", 32'h2, rd);
    wait_for(sig_error, 1'b1, "error_intr to rise");
    write_reg(sha256_pkg::intr_sts_off, 32'h2, rc);
    read_reg(sha256_pkg::intr_sts_off, rd, rc);
    check_word("intr_sts", 32'h0, rd);
    wait_for(sig_error, 1'b0, "error_intr to fall");
  endtask

  // Record is v, mode, block count, blocks, digest; # starts a comment line
  task automatic run_vectors();
    int fd;
    int code;
    int count;
    logic [7:0] marker;
    logic [8*128-1:0] line_buf;
    sha256_pkg::word_t mode_w;
    sha256_pkg::word_t nblk_w;
    count = 0;
    fd = $fopen("sha256_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the vector file sha256_input.txt");
      return;
    end
    code = $fscanf(fd, " %c", marker);
    while (code == 1) begin
      if (marker == "#") begin
        code = $fgets(line_buf, fd);
      end else if (marker == "v") begin
        code = $fscanf(fd, "%h %h", mode_w, nblk_w);
        if (nblk_w != 32'd1 && nblk_w != 32'd2) begin
          errors++;
          $display("Vector %0d has a block count other than one or two", count);
          break;
        end
        for (int b = 0; b < int'(nblk_w); b++) begin
          for (int i = 0; i < 16; i++) begin
            code = $fscanf(fd, "%h", blk[b][i]);
          end
        end
        for (int i = 0; i < 8; i++) begin
          code = $fscanf(fd, "%h", exp_dig[i]);
        end
        for (int b = 0; b < int'(nblk_w); b++) begin
          hash_block(b, mode_w[0], b == 0, 1'b0);
        end
        check_digest(mode_w[0]);
        if (count == 0) begin
          saved_mode = mode_w[0];
          for (int i = 0; i < 16; i++) begin
            saved_blk[i] = blk[0][i];
          end
          for (int i = 0; i < 8; i++) begin
            saved_dig[i] = exp_dig[i];
          end
        end
        count++;
      end else begin
        errors++;
        $display("Vector file holds an unexpected character at record %0d", count);
        break;
      end
      code = $fscanf(fd, " %c", marker);
    end
    $fclose(fd);
    if (count < 3) begin
      errors++;
      $display("Only %0d of 3 vectors were read from the file", count);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main_seq
    sha256_pkg::word_t rd;
    sha256_pkg::resp_t rc;
    seed = 32'h26146974;
    checks = 0;
    errors = 0;
    timeouts = 0;
    timed_out = 1'b0;
    run_done = 1'b0;
    reset_n <= 1'b0;
    awvalid <= 1'b0;
    awaddr  <= '0;
    wvalid  <= 1'b0;
    wdata   <= '0;
    wstrb   <= 4'hf;
    bready  <= 1'b0;
    arvalid <= 1'b0;
    araddr  <= '0;
    rready  <= 1'b0;
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);

    // State after reset
    @(negedge clk);
    check_word("awready", 32'h1, {31'b0, awready});
    check_word("wready", 32'h1, {31'b0, wready});
    check_word("arready", 32'h1, {31'b0, arready});
    check_word("notif_intr", 32'h0, {31'b0, notif_intr});
    check_word("error_intr", 32'h0, {31'b0, error_intr});
    read_reg(sha256_pkg::status_off, rd, rc);
    check_word("status", 32'h1, rd);
    read_reg(sha256_pkg::intr_sts_off, rd, rc);
    check_word("intr_sts", 32'h0, rd);

    // Vectors with the completion interrupt enabled
    write_reg(sha256_pkg::intr_en_off, 32'h1, rc);
    run_vectors();

    // Bad accesses, each flagged on its own
    write_reg(sha256_pkg::intr_en_off, 32'h3, rc);
    write_reg(8'h10, 32'hdeadbeef, rc);
    check_word("bresp", 32'h2, {30'b0, rc});
    verify_error_flag();
    write_reg(sha256_pkg::digest_off + 8'h04, 32'h12345678, rc);
    check_word("bresp", 32'h2, {30'b0, rc});
    verify_error_flag();
    read_reg(8'h30, rd, rc);
    check_word("rresp", 32'h2, {30'b0, rc});
    check_word("rdata", 32'h0, rd);
    verify_error_flag();

    // NEXT while busy, first vector again
    for (int i = 0; i < 16; i++) begin
      blk[0][i] = saved_blk[i];
    end
    for (int i = 0; i < 8; i++) begin
      exp_dig[i] = saved_dig[i];
    end
    hash_block(0, saved_mode, 1'b1, 1'b1);
    check_digest(saved_mode);
    read_reg(sha256_pkg::intr_sts_off, rd, rc);
    check_word("intr_sts", 32'h2, rd);
    run_done = 1'b1;
  end

  // End of run, with an overall cycle limit
  initial begin : end_of_run
    int cycles;
    cycles = 0;
    while (!run_done && !timed_out && cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (cycles >= max_cycles) begin
      timeouts++;
      $display("The run did not complete within %0d cycles", max_cycles);
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
